/* src/sms_bus_pkg.sv */
package sms_bus_pkg;

  // ============================================================
  // CPU bus
  // ============================================================
  localparam int ADDR_W = 16;
  localparam int DATA_W = 8;

  typedef logic [DATA_W-1:0] byte_t;

  // ============================================================
  // I/O ports, matched against the low address byte
  // ============================================================
  localparam byte_t VDP_DATA_PORT = 8'hBE;
  localparam byte_t VDP_CTRL_PORT = 8'hBF;
  localparam byte_t MEM_CTRL_PORT = 8'h3E;

  // Controller ports, all three alias the same byte
  localparam byte_t CTRL_PORT_0 = 8'hDC;
  localparam byte_t CTRL_PORT_1 = 8'hDD;
  localparam byte_t CTRL_PORT_2 = 8'hDE;

  // ============================================================
  // Memory map
  // ============================================================
  localparam byte_t MEM_CTRL_RESET = 8'hF7;  // BIOS on, cartridge off
  localparam int CART_SELECT_BIT = 3;
  localparam logic [1:0] RAM_SLOT = 2'd3;    // C000-FFFF
  localparam int RAM_ADDR_W = 13;            // 8 KB, seen twice in the top slot

  // Divide ratio of the CPU clock enable
  localparam int CLK_DIV = 7;

  // Joypad inputs
  localparam int BTN_W = 7;

endpackage

/* src/vdp_pkg.sv */
package vdp_pkg;

  // ============================================================
  // Register file and memories
  // ============================================================
  localparam int VDP_REG_COUNT = 11;
  localparam int VRAM_ADDR_W = 14;  // 16 KB
  localparam int CRAM_ADDR_W = 5;   // 32 palette entries

  typedef logic [VRAM_ADDR_W-1:0] vram_addr_t;

  // Two bits each of blue, green, red
  typedef logic [5:0] color_t;

  // Video mode 0 to 4, mode 4 is the native SMS mode
  typedef logic [2:0] vdp_mode_t;

  // ============================================================
  // Second control byte, bits 7:6
  // ============================================================
  localparam logic [1:0] CMD_REG_WRITE = 2'd2;
  localparam logic [1:0] CMD_CRAM = 2'd3;

  // Low five status bits when no sprite overflow is flagged
  localparam logic [4:0] STATUS_NO_SPRITE = 5'h1F;

endpackage

/* src/cpu_clock_enable.sv */
module cpu_clock_enable (
  input  logic cpuClock,
  input  logic n_hard_reset,
  output logic o_enable,
  output logic o_edge
);

  logic [$clog2(sms_bus_pkg::CLK_DIV)-1:0] count;
  logic enable_q;

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      count    <= '0;
      enable_q <= 1'b0;
    end else begin
      enable_q <= o_enable;
      if (count == sms_bus_pkg::CLK_DIV - 1) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  assign o_enable = count[$bits(count)-1];  // High for counts 4 to 6
  assign o_edge   = o_enable & ~enable_q;

endmodule

/* src/sync_ram.sv */
module sync_ram #(
  parameter type word_t = logic [7:0],
  parameter int  ADDR_W = 8
) (
  input  logic              cpuClock,
  input  logic              i_we,
  input  logic [ADDR_W-1:0] i_addr,
  input  word_t             i_wdata,
  output word_t             o_rdata
);

  word_t mem [2**ADDR_W];

  // Read returns the old word during a write
  always_ff @(posedge cpuClock) begin
    if (i_we) begin
      mem[i_addr] <= i_wdata;
    end
    o_rdata <= mem[i_addr];
  end

endmodule

/* src/io_bus_decoder.sv */
module io_bus_decoder (
  input  logic                              cpuClock,
  input  logic                              n_hard_reset,
  input  logic                              i_edge,
  input  logic [sms_bus_pkg::ADDR_W-1:0]    i_addr,
  input  sms_bus_pkg::byte_t                i_data,
  input  logic                              i_n_rd,
  input  logic                              i_n_wr,
  input  logic                              i_n_mreq,
  input  logic                              i_n_iorq,
  input  logic [sms_bus_pkg::BTN_W-1:0]     i_btn,
  input  sms_bus_pkg::byte_t                i_bios_data,
  input  sms_bus_pkg::byte_t                i_cart_data,
  input  sms_bus_pkg::byte_t                i_ram_data,
  input  sms_bus_pkg::byte_t                i_vdp_data,
  input  sms_bus_pkg::byte_t                i_status,
  output logic                              o_ram_we,
  output logic                              o_vdp_data_wr,
  output logic                              o_vdp_data_rd_done,
  output logic                              o_vdp_ctrl_wr,
  output logic                              o_status_rd_done,
  output sms_bus_pkg::byte_t                o_cpu_din,
  output logic                              o_cart_selected
);

  logic io_rd, io_wr, mem_rd, mem_wr;
  logic sel_vdp_data, sel_vdp_ctrl, sel_ctrl, sel_mem_ctrl;
  logic in_ram_slot;
  logic wr_commit, wr_done;
  logic data_rd_q, status_rd_q;
  sms_bus_pkg::byte_t mem_ctrl;
  sms_bus_pkg::byte_t joy_data;

  // ============================================================
  // Strobe and address decode
  // ============================================================
  assign io_rd  = ~i_n_rd & ~i_n_iorq;
  assign io_wr  = ~i_n_wr & ~i_n_iorq;
  assign mem_rd = ~i_n_rd & ~i_n_mreq;
  assign mem_wr = ~i_n_wr & ~i_n_mreq;

  assign sel_vdp_data = i_addr[7:0] == sms_bus_pkg::VDP_DATA_PORT;
  assign sel_vdp_ctrl = i_addr[7:0] == sms_bus_pkg::VDP_CTRL_PORT;
  assign sel_mem_ctrl = i_addr[7:0] == sms_bus_pkg::MEM_CTRL_PORT;
  assign sel_ctrl     = (i_addr[7:0] == sms_bus_pkg::CTRL_PORT_0) ||
                        (i_addr[7:0] == sms_bus_pkg::CTRL_PORT_1) ||
                        (i_addr[7:0] == sms_bus_pkg::CTRL_PORT_2);

  assign in_ram_slot = i_addr[sms_bus_pkg::ADDR_W-1 -: 2] == sms_bus_pkg::RAM_SLOT;

  // A write commits once, on the first edge while its strobe is low
  assign wr_commit = i_edge & (io_wr | mem_wr) & ~wr_done;

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      wr_done     <= 1'b0;
      data_rd_q   <= 1'b0;
      status_rd_q <= 1'b0;
      mem_ctrl    <= sms_bus_pkg::MEM_CTRL_RESET;
    end else begin
      if (!(io_wr || mem_wr)) begin
        wr_done <= 1'b0;
      end else if (wr_commit) begin
        wr_done <= 1'b1;
      end
      if (i_edge) begin  // Read history is sampled on CPU edges only
        data_rd_q   <= io_rd & sel_vdp_data;
        status_rd_q <= io_rd & sel_vdp_ctrl;
      end
      if (wr_commit && io_wr && sel_mem_ctrl) begin
        mem_ctrl <= i_data;
      end
    end
  end

  assign o_vdp_data_wr = wr_commit & io_wr & sel_vdp_data;
  assign o_vdp_ctrl_wr = wr_commit & io_wr & sel_vdp_ctrl;
  assign o_ram_we      = wr_commit & mem_wr & in_ram_slot;

  // Read ends on the first edge after its strobe went away
  assign o_vdp_data_rd_done = i_edge & data_rd_q & ~(io_rd & sel_vdp_data);
  assign o_status_rd_done   = i_edge & status_rd_q & ~(io_rd & sel_vdp_ctrl);

  assign o_cart_selected = mem_ctrl[sms_bus_pkg::CART_SELECT_BIT];

  // ============================================================
  // CPU read data
  // ============================================================
  assign joy_data = {~i_btn[2:1], ~i_btn[6:1]};  // Active-low pads

  always_comb begin
    if (io_rd && sel_vdp_data) begin
      o_cpu_din = i_vdp_data;
    end else if (io_rd && sel_vdp_ctrl) begin
      o_cpu_din = i_status;
    end else if (io_rd && sel_ctrl) begin
      o_cpu_din = joy_data;
    end else if (mem_rd && !in_ram_slot) begin
      o_cpu_din = o_cart_selected ? i_cart_data : i_bios_data;
    end else begin
      o_cpu_din = i_ram_data;
    end
  end

endmodule

/* src/vdp_control_port.sv */
module vdp_control_port (
  input  logic                  cpuClock,
  input  logic                  n_hard_reset,
  input  logic                  i_data_wr,
  input  logic                  i_data_rd_done,
  input  logic                  i_ctrl_wr,
  input  logic                  i_status_rd_done,
  input  sms_bus_pkg::byte_t    i_data,
  input  logic                  i_frame_interrupt,
  input  logic                  i_sprite_collision,
  input  logic                  i_sprite_overflow,
  input  logic [4:0]            i_sprite5,
  output vdp_pkg::vram_addr_t   o_vram_addr,
  output logic                  o_vram_we,
  output logic                  o_cram_we,
  output logic                  o_cram_selected,
  output sms_bus_pkg::byte_t    o_regs [vdp_pkg::VDP_REG_COUNT],
  output sms_bus_pkg::byte_t    o_status
);

  logic second_byte;
  logic expect_second;
  sms_bus_pkg::byte_t first_byte;
  logic [3:0] reg_index;
  logic irq_flag;
  logic collision_flag;

  // A read that just ended drops a half-written address first
  assign expect_second = second_byte & ~(i_data_rd_done | i_status_rd_done);
  assign reg_index     = i_data[3:0];

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      second_byte     <= 1'b0;
      o_vram_addr     <= '0;
      o_cram_selected <= 1'b0;
      for (int i = 0; i < vdp_pkg::VDP_REG_COUNT; i++) begin
        o_regs[i] <= '0;
      end
    end else begin
      if (i_data_wr || i_data_rd_done) begin
        o_vram_addr <= o_vram_addr + 1'b1;  // Auto-increment
      end
      if (i_data_wr) begin
        second_byte <= 1'b0;
      end else if (i_ctrl_wr) begin
        second_byte <= ~expect_second;
        if (!expect_second) begin
          first_byte <= i_data;
        end else begin
          case (i_data[7:6])
            vdp_pkg::CMD_REG_WRITE: begin
              if (reg_index < vdp_pkg::VDP_REG_COUNT) begin
                o_regs[reg_index] <= first_byte;
              end else begin
                o_vram_addr     <= vdp_pkg::vram_addr_t'(first_byte[5:0]);
                o_cram_selected <= 1'b1;
              end
            end
            vdp_pkg::CMD_CRAM: begin
              o_vram_addr     <= vdp_pkg::vram_addr_t'(first_byte[5:0]);
              o_cram_selected <= 1'b1;
            end
            default: begin  // VRAM read or write setup
              o_vram_addr     <= {i_data[5:0], first_byte};
              o_cram_selected <= 1'b0;
            end
          endcase
        end
      end else begin
        second_byte <= expect_second;
      end
    end
  end

  assign o_vram_we = i_data_wr & ~o_cram_selected;
  assign o_cram_we = i_data_wr & o_cram_selected;

  // ============================================================
  // Status flags
  // ============================================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      irq_flag       <= 1'b0;
      collision_flag <= 1'b0;
    end else begin
      // New event wins over a clear in the same cycle
      irq_flag       <= i_frame_interrupt | (irq_flag & ~i_status_rd_done);
      collision_flag <= i_sprite_collision | (collision_flag & ~i_status_rd_done);
    end
  end

  assign o_status = {irq_flag, i_sprite_overflow, collision_flag,
                     i_sprite_overflow ? i_sprite5 : vdp_pkg::STATUS_NO_SPRITE};

endmodule

/* src/vdp_register_decode.sv */
module vdp_register_decode (
  input  sms_bus_pkg::byte_t   i_regs [vdp_pkg::VDP_REG_COUNT],
  output vdp_pkg::vdp_mode_t   o_mode,
  output vdp_pkg::vram_addr_t  o_name_table_addr,
  output vdp_pkg::vram_addr_t  o_sprite_attr_addr,
  output vdp_pkg::vram_addr_t  o_pattern_addr,
  output logic                 o_video_on
);

  // Mode bits M4..M1 are spread over registers 0 and 1
  always_comb begin
    if (i_regs[0][2]) begin
      o_mode = 3'd4;
    end else if (i_regs[1][3]) begin
      o_mode = 3'd3;
    end else if (i_regs[0][1]) begin
      o_mode = 3'd2;
    end else if (i_regs[1][4]) begin
      o_mode = 3'd1;
    end else begin
      o_mode = 3'd0;
    end
  end

  assign o_name_table_addr  = {i_regs[2][3:1], 11'b0};  // 2 KB steps
  assign o_sprite_attr_addr = {i_regs[5][6:1], 8'b0};   // 256 byte steps

  // Mode 4 only picks one of two 8 KB halves
  assign o_pattern_addr = (o_mode == 3'd4) ? {i_regs[6][2], 13'b0}
                                           : {i_regs[6][2:0], 11'b0};

  assign o_video_on = i_regs[1][6];

endmodule

/* src/sms_io_top.sv */
module sms_io_top (
  input  logic                            cpuClock,
  input  logic                            n_hard_reset,
  input  logic [sms_bus_pkg::ADDR_W-1:0]  i_addr,
  input  sms_bus_pkg::byte_t              i_data,
  input  logic                            i_n_rd,
  input  logic                            i_n_wr,
  input  logic                            i_n_mreq,
  input  logic                            i_n_iorq,
  input  sms_bus_pkg::byte_t              i_bios_data,
  input  sms_bus_pkg::byte_t              i_cart_data,
  input  logic [sms_bus_pkg::BTN_W-1:0]   i_btn,
  input  logic                            i_frame_interrupt,
  input  logic                            i_sprite_collision,
  input  logic                            i_sprite_overflow,
  input  logic [4:0]                      i_sprite5,
  output logic                            o_cpu_clock_enable,
  output sms_bus_pkg::byte_t              o_cpu_din,
  output vdp_pkg::vdp_mode_t              o_mode,
  output vdp_pkg::vram_addr_t             o_name_table_addr,
  output vdp_pkg::vram_addr_t             o_sprite_attr_addr,
  output vdp_pkg::vram_addr_t             o_pattern_addr,
  output logic                            o_video_on,
  output logic                            o_cart_selected
);

  logic cpu_edge;
  logic ram_we, vram_we, cram_we, cram_selected;
  logic vdp_data_wr, vdp_data_rd_done, vdp_ctrl_wr, status_rd_done;
  vdp_pkg::vram_addr_t vram_addr;
  vdp_pkg::color_t cram_rdata;
  sms_bus_pkg::byte_t ram_rdata, vram_rdata, vdp_status;
  sms_bus_pkg::byte_t vdp_regs [vdp_pkg::VDP_REG_COUNT];

  // Palette entries are zero-extended to a full byte
  wire sms_bus_pkg::byte_t vdp_rdata = cram_selected ? {2'b00, cram_rdata} : vram_rdata;

  cpu_clock_enable u_clock_enable (
    .cpuClock     (cpuClock),
    .n_hard_reset (n_hard_reset),
    .o_enable     (o_cpu_clock_enable),
    .o_edge       (cpu_edge)
  );

  // ============================================================
  // CPU bus side
  // ============================================================
  io_bus_decoder u_decoder (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_edge             (cpu_edge),
    .i_addr             (i_addr),
    .i_data             (i_data),
    .i_n_rd             (i_n_rd),
    .i_n_wr             (i_n_wr),
    .i_n_mreq           (i_n_mreq),
    .i_n_iorq           (i_n_iorq),
    .i_btn              (i_btn),
    .i_bios_data        (i_bios_data),
    .i_cart_data        (i_cart_data),
    .i_ram_data         (ram_rdata),
    .i_vdp_data         (vdp_rdata),
    .i_status           (vdp_status),
    .o_ram_we           (ram_we),
    .o_vdp_data_wr      (vdp_data_wr),
    .o_vdp_data_rd_done (vdp_data_rd_done),
    .o_vdp_ctrl_wr      (vdp_ctrl_wr),
    .o_status_rd_done   (status_rd_done),
    .o_cpu_din          (o_cpu_din),
    .o_cart_selected    (o_cart_selected)
  );

  sync_ram #(
    .word_t (sms_bus_pkg::byte_t),
    .ADDR_W (sms_bus_pkg::RAM_ADDR_W)
  ) u_work_ram (
    .cpuClock (cpuClock),
    .i_we     (ram_we),
    .i_addr   (i_addr[sms_bus_pkg::RAM_ADDR_W-1:0]),  // Upper bits ignored, mirrored
    .i_wdata  (i_data),
    .o_rdata  (ram_rdata)
  );

  // ============================================================
  // VDP port logic and video memories
  // ============================================================
  vdp_control_port u_vdp_port (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_data_wr          (vdp_data_wr),
    .i_data_rd_done     (vdp_data_rd_done),
    .i_ctrl_wr          (vdp_ctrl_wr),
    .i_status_rd_done   (status_rd_done),
    .i_data             (i_data),
    .i_frame_interrupt  (i_frame_interrupt),
    .i_sprite_collision (i_sprite_collision),
    .i_sprite_overflow  (i_sprite_overflow),
    .i_sprite5          (i_sprite5),
    .o_vram_addr        (vram_addr),
    .o_vram_we          (vram_we),
    .o_cram_we          (cram_we),
    .o_cram_selected    (cram_selected),
    .o_regs             (vdp_regs),
    .o_status           (vdp_status)
  );

  vdp_register_decode u_reg_decode (
    .i_regs             (vdp_regs),
    .o_mode             (o_mode),
    .o_name_table_addr  (o_name_table_addr),
    .o_sprite_attr_addr (o_sprite_attr_addr),
    .o_pattern_addr     (o_pattern_addr),
    .o_video_on         (o_video_on)
  );

  sync_ram #(
    .word_t (sms_bus_pkg::byte_t),
    .ADDR_W (vdp_pkg::VRAM_ADDR_W)
  ) u_vram (
    .cpuClock (cpuClock),
    .i_we     (vram_we),
    .i_addr   (vram_addr),
    .i_wdata  (i_data),
    .o_rdata  (vram_rdata)
  );

  sync_ram #(
    .word_t (vdp_pkg::color_t),
    .ADDR_W (vdp_pkg::CRAM_ADDR_W)
  ) u_cram (
    .cpuClock (cpuClock),
    .i_we     (cram_we),
    .i_addr   (vram_addr[vdp_pkg::CRAM_ADDR_W-1:0]),
    .i_wdata  (i_data[5:0]),
    .o_rdata  (cram_rdata)
  );

endmodule

/* dv/sms_io_assertions.sv */
module sms_io_checker (
  input logic                           cpuClock,
  input logic                           n_hard_reset,
  input logic [sms_bus_pkg::ADDR_W-1:0] i_addr,
  input sms_bus_pkg::byte_t             i_data,
  input logic                           i_n_rd,
  input logic                           i_n_wr,
  input logic                           i_n_mreq,
  input logic                           i_n_iorq,
  input sms_bus_pkg::byte_t             i_bios_data,
  input sms_bus_pkg::byte_t             i_cart_data,
  input logic [sms_bus_pkg::BTN_W-1:0]  i_btn,
  input logic                           i_frame_interrupt,
  input logic                           i_sprite_collision,
  input logic                           i_sprite_overflow,
  input logic [4:0]                     i_sprite5,
  input logic                           o_cpu_clock_enable,
  input sms_bus_pkg::byte_t             o_cpu_din,
  input vdp_pkg::vdp_mode_t             o_mode,
  input vdp_pkg::vram_addr_t            o_name_table_addr,
  input vdp_pkg::vram_addr_t            o_sprite_attr_addr,
  input vdp_pkg::vram_addr_t            o_pattern_addr,
  input logic                           o_video_on,
  input logic                           o_cart_selected
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;
  int hits [7];  // Times each check group was reached

  logic en_q, cpu_edge, wr_seen, wr_first;
  logic [6:0] en_hist;
  int cycles_out;
  logic io_rd, io_wr, mem_rd, mem_wr, in_slot;
  logic data_rd_q, stat_rd_q, data_done, stat_done, second_eff;
  logic mem_rd_q, vdata_rd_q;
  logic [sms_bus_pkg::ADDR_W-1:0] addr_q;
  logic [7:0] port;
  logic ctrl_second, cram_sel, cart_sel, irq, col;
  sms_bus_pkg::byte_t first;
  vdp_pkg::vram_addr_t vaddr;
  sms_bus_pkg::byte_t regs [vdp_pkg::VDP_REG_COUNT];
  sms_bus_pkg::byte_t ram [2**sms_bus_pkg::RAM_ADDR_W];
  logic ram_ok [2**sms_bus_pkg::RAM_ADDR_W];
  sms_bus_pkg::byte_t vram [2**vdp_pkg::VRAM_ADDR_W];
  logic vram_ok [2**vdp_pkg::VRAM_ADDR_W];
  vdp_pkg::color_t cram [2**vdp_pkg::CRAM_ADDR_W];
  logic cram_ok [2**vdp_pkg::CRAM_ADDR_W];
  vdp_pkg::vdp_mode_t exp_mode;
  sms_bus_pkg::byte_t exp_vdata, exp_status;
  logic vdata_ok, ram_chk, rom_chk, vdata_chk, stat_chk, joy_chk;

  // ============================================================
  // Bus decode from the strobes
  // ============================================================
  assign io_rd   = !i_n_rd && !i_n_iorq;
  assign io_wr   = !i_n_wr && !i_n_iorq;
  assign mem_rd  = !i_n_rd && !i_n_mreq;
  assign mem_wr  = !i_n_wr && !i_n_mreq;
  assign port    = i_addr[7:0];
  assign in_slot = i_addr[15:14] == 2'b11;
  assign cpu_edge  = o_cpu_clock_enable && !en_q;
  assign wr_first  = cpu_edge && (io_wr || mem_wr) && !wr_seen;  // One commit per access
  assign data_done = cpu_edge && data_rd_q && !(io_rd && port == 8'hBE);
  assign stat_done = cpu_edge && stat_rd_q && !(io_rd && port == 8'hBF);
  assign second_eff = ctrl_second && !(data_done || stat_done);

  always_comb begin
    if (regs[0][2]) exp_mode = 3'd4;
    else if (regs[1][3]) exp_mode = 3'd3;
    else if (regs[0][1]) exp_mode = 3'd2;
    else if (regs[1][4]) exp_mode = 3'd1;
    else exp_mode = 3'd0;
  end

  assign exp_vdata  = cram_sel ? {2'b00, cram[vaddr[4:0]]} : vram[vaddr];
  assign vdata_ok   = cram_sel ? cram_ok[vaddr[4:0]] : vram_ok[vaddr];
  assign exp_status = {irq, i_sprite_overflow, col, i_sprite_overflow ? i_sprite5 : 5'h1F};

  assign rom_chk   = mem_rd && !in_slot;
  assign ram_chk   = mem_rd && mem_rd_q && in_slot && i_addr == addr_q && ram_ok[i_addr[12:0]];
  assign vdata_chk = io_rd && port == 8'hBE && vdata_rd_q && vdata_ok;
  assign stat_chk  = io_rd && port == 8'hBF;
  assign joy_chk   = io_rd && (port == 8'hDC || port == 8'hDD || port == 8'hDE);

  // ============================================================
  // Shadow models
  // ============================================================
  always @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      en_q <= 1'b0;
      en_hist <= '0;
      cycles_out <= 0;
      {wr_seen, data_rd_q, stat_rd_q, mem_rd_q, vdata_rd_q} <= '0;
      {ctrl_second, cram_sel, cart_sel, irq, col} <= '0;  // F7 keeps BIOS on
      first <= '0;
      vaddr <= '0;
      addr_q <= '0;
      for (int i = 0; i < vdp_pkg::VDP_REG_COUNT; i++) regs[i] <= '0;
      for (int i = 0; i < 2**sms_bus_pkg::RAM_ADDR_W; i++) ram_ok[i] <= 1'b0;
      for (int i = 0; i < 2**vdp_pkg::VRAM_ADDR_W; i++) vram_ok[i] <= 1'b0;
      for (int i = 0; i < 2**vdp_pkg::CRAM_ADDR_W; i++) cram_ok[i] <= 1'b0;
    end else begin
      en_q <= o_cpu_clock_enable;
      en_hist <= {en_hist[5:0], o_cpu_clock_enable};
      if (cycles_out < 8) cycles_out <= cycles_out + 1;
      mem_rd_q <= mem_rd;
      addr_q <= i_addr;
      vdata_rd_q <= io_rd && port == 8'hBE;
      if (!(io_wr || mem_wr)) wr_seen <= 1'b0;
      else if (wr_first) wr_seen <= 1'b1;
      if (cpu_edge) begin
        data_rd_q <= io_rd && port == 8'hBE;
        stat_rd_q <= io_rd && port == 8'hBF;
      end
      irq <= i_frame_interrupt || (irq && !stat_done);  // Sticky until status read
      col <= i_sprite_collision || (col && !stat_done);
      if (wr_first && mem_wr && in_slot) begin
        ram[i_addr[12:0]] <= i_data;
        ram_ok[i_addr[12:0]] <= 1'b1;
      end
      if (wr_first && io_wr && port == 8'h3E) cart_sel <= i_data[3];
      if ((wr_first && io_wr && port == 8'hBE) || data_done) vaddr <= vaddr + 1'b1;
      if (wr_first && io_wr && port == 8'hBE) begin
        ctrl_second <= 1'b0;
        if (cram_sel) begin
          cram[vaddr[4:0]] <= i_data[5:0];
          cram_ok[vaddr[4:0]] <= 1'b1;
        end else begin
          vram[vaddr] <= i_data;
          vram_ok[vaddr] <= 1'b1;
        end
      end else if (wr_first && io_wr && port == 8'hBF) begin
        ctrl_second <= !second_eff;
        if (!second_eff) begin
          first <= i_data;
        end else if (!i_data[7]) begin
          vaddr <= {i_data[5:0], first};
          cram_sel <= 1'b0;
        end else if (i_data[7:6] == 2'b10 && i_data[3:0] < 4'd11) begin
          regs[i_data[3:0]] <= first;
        end else begin
          vaddr <= {8'h00, first[5:0]};
          cram_sel <= 1'b1;
        end
      end else begin
        ctrl_second <= second_eff;
      end
      if (cycles_out >= 7) hits[0] <= hits[0] + 1;
      if (rom_chk) hits[1] <= hits[1] + 1;
      if (ram_chk) hits[2] <= hits[2] + 1;
      if (exp_mode != 3'd0) hits[3] <= hits[3] + 1;
      if (vdata_chk) hits[4] <= hits[4] + 1;
      if (stat_chk) hits[5] <= hits[5] + 1;
      if (joy_chk) hits[6] <= hits[6] + 1;
    end
  end

  // ============================================================
  // Assertions
  // ============================================================
  a_enable: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    cycles_out >= 7 |-> $countones(en_hist) == 3)
    else begin fail_count = fail_count + 1; $error("Clock enable duty wrong"); end

  a_rom: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    rom_chk |-> o_cpu_din == (cart_sel ? i_cart_data : i_bios_data))
    else begin fail_count = fail_count + 1; $error("BIOS/cartridge read wrong"); end

  a_cart: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    o_cart_selected == cart_sel)
    else begin fail_count = fail_count + 1; $error("Cartridge select wrong"); end

  a_ram: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    ram_chk |-> o_cpu_din == ram[i_addr[12:0]])
    else begin fail_count = fail_count + 1; $error("Work RAM read wrong"); end

  a_decode: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    o_mode == exp_mode && o_video_on == regs[1][6] &&
    o_name_table_addr == {regs[2][3:1], 11'b0} &&
    o_sprite_attr_addr == {regs[5][6:1], 8'b0} &&
    o_pattern_addr == ((exp_mode == 3'd4) ? {regs[6][2], 13'b0} : {regs[6][2:0], 11'b0}))
    else begin fail_count = fail_count + 1; $error("Register decode wrong"); end

  a_vdata: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    vdata_chk |-> o_cpu_din == exp_vdata)
    else begin fail_count = fail_count + 1; $error("VRAM/CRAM read wrong"); end

  a_status: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    stat_chk |-> o_cpu_din == exp_status)
    else begin fail_count = fail_count + 1; $error("Status byte wrong"); end

  a_joypad: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    joy_chk |-> o_cpu_din == {~i_btn[2:1], ~i_btn[6:1]})
    else begin fail_count = fail_count + 1; $error("Controller byte wrong"); end

endmodule

bind sms_io_top sms_io_checker u_checker (
  .cpuClock           (cpuClock),
  .n_hard_reset       (n_hard_reset),
  .i_addr             (i_addr),
  .i_data             (i_data),
  .i_n_rd             (i_n_rd),
  .i_n_wr             (i_n_wr),
  .i_n_mreq           (i_n_mreq),
  .i_n_iorq           (i_n_iorq),
  .i_bios_data        (i_bios_data),
  .i_cart_data        (i_cart_data),
  .i_btn              (i_btn),
  .i_frame_interrupt  (i_frame_interrupt),
  .i_sprite_collision (i_sprite_collision),
  .i_sprite_overflow  (i_sprite_overflow),
  .i_sprite5          (i_sprite5),
  .o_cpu_clock_enable (o_cpu_clock_enable),
  .o_cpu_din          (o_cpu_din),
  .o_mode             (o_mode),
  .o_name_table_addr  (o_name_table_addr),
  .o_sprite_attr_addr (o_sprite_attr_addr),
  .o_pattern_addr     (o_pattern_addr),
  .o_video_on         (o_video_on),
  .o_cart_selected    (o_cart_selected)
);

/* dv/sms_io_tb.sv */
module sms_io_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 8;
  localparam int TEST_COUNT = 6;
  localparam int CYCLES_PER_TEST = 2000;

  logic cpuClock = 1'b0;
  logic n_hard_reset;
  logic [15:0] i_addr;
  sms_bus_pkg::byte_t i_data, i_bios_data, i_cart_data, o_cpu_din;
  logic i_n_rd, i_n_wr, i_n_mreq, i_n_iorq;
  logic [6:0] i_btn;
  logic i_frame_interrupt, i_sprite_collision, i_sprite_overflow;
  logic [4:0] i_sprite5;
  logic o_cpu_clock_enable, o_video_on, o_cart_selected;
  vdp_pkg::vdp_mode_t o_mode;
  vdp_pkg::vram_addr_t o_name_table_addr, o_sprite_attr_addr, o_pattern_addr;
  logic [31:0] lfsr_state = 32'h3500_4246;
  logic [31:0] r, s;
  int errors = 0;
  int assert_fails;

  always #(CLK_PERIOD / 2) cpuClock = ~cpuClock;

  sms_io_top dut (.*);

  function automatic logic [31:0] lfsr_step(input logic [31:0] st);
    return st[0] ? ((st >> 1) ^ 32'h8020_0003) : (st >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic random_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  // Holds one access for 14 cycles, then idles long enough for a read to end
  task automatic bus_access(input logic [15:0] addr, input logic [7:0] data,
                            input logic is_io, input logic is_write);
    @(posedge cpuClock);
    #1;
    i_addr = addr;
    i_data = data;
    i_n_mreq = is_io;
    i_n_iorq = !is_io;
    i_n_rd = is_write;
    i_n_wr = !is_write;
    repeat (14) @(posedge cpuClock);
    #1;
    {i_n_rd, i_n_wr, i_n_mreq, i_n_iorq} = 4'hF;
    repeat (7) @(posedge cpuClock);
    #1;
  endtask

  task automatic control_write(input logic [7:0] b0, input logic [7:0] b1);
    bus_access(16'h00BF, b0, 1'b1, 1'b1);
    bus_access(16'h00BF, b1, 1'b1, 1'b1);
  endtask

  initial begin
    #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Timeout: the tests did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    n_hard_reset = 1'b0;
    i_addr = '0;
    i_data = '0;
    {i_n_rd, i_n_wr, i_n_mreq, i_n_iorq} = 4'hF;
    i_bios_data = 8'h31;
    i_cart_data = 8'hC3;
    i_btn = '0;
    {i_frame_interrupt, i_sprite_collision, i_sprite_overflow} = '0;
    i_sprite5 = '0;
    repeat (16) @(posedge cpuClock);
    #1;
    n_hard_reset = 1'b1;

    // ============================================================
    // Clock enable, then BIOS/cartridge and mirrored RAM
    // ============================================================
    repeat (30) @(posedge cpuClock);
    bus_access(16'h0123, 8'h00, 1'b0, 1'b0);
    bus_access(16'h003E, 8'hFF, 1'b1, 1'b1);  // Cartridge on
    bus_access(16'h8456, 8'h00, 1'b0, 1'b0);
    for (int i = 0; i < 4; i++) begin
      random_bits(14, r);
      random_bits(8, s);
      bus_access({2'b11, r[13:0]}, s[7:0], 1'b0, 1'b1);
      bus_access({2'b11, ~r[13], r[12:0]}, 8'h00, 1'b0, 1'b0);  // Mirror copy
    end

    // ============================================================
    // Registers and decode
    // ============================================================
    control_write(8'h04, 8'h80);  // Mode 4
    control_write(8'h40, 8'h81);
    control_write(8'h0A, 8'h82);
    control_write(8'h5A, 8'h85);
    control_write(8'h06, 8'h86);
    control_write(8'h00, 8'h80);
    control_write(8'h08, 8'h81);
    control_write(8'h02, 8'h80);
    control_write(8'h10, 8'h81);
    control_write(8'h00, 8'h80);  // Mode 1
    control_write(8'h55, 8'h8C);  // Index 12
    random_bits(8, r);
    control_write(r[7:0], 8'h86);

    // VRAM block write then read back, then one CRAM word
    random_bits(14, r);
    control_write(r[7:0], {2'b01, r[13:8]});
    for (int i = 0; i < 8; i++) begin
      random_bits(8, s);
      bus_access(16'h00BE, s[7:0], 1'b1, 1'b1);
    end
    control_write(r[7:0], {2'b00, r[13:8]});
    for (int i = 0; i < 8; i++) bus_access(16'h00BE, 8'h00, 1'b1, 1'b0);
    control_write(8'h05, 8'hC0);
    bus_access(16'h00BE, 8'hEB, 1'b1, 1'b1);
    control_write(8'h05, 8'hC0);
    bus_access(16'h00BE, 8'h00, 1'b1, 1'b0);

    // ============================================================
    // Status flags and controller ports
    // ============================================================
    @(posedge cpuClock);
    #1;
    {i_frame_interrupt, i_sprite_collision} = 2'b11;
    @(posedge cpuClock);
    #1;
    {i_frame_interrupt, i_sprite_collision} = 2'b00;
    bus_access(16'h00BF, 8'h00, 1'b1, 1'b0);
    bus_access(16'h00BF, 8'h00, 1'b1, 1'b0);
    random_bits(5, r);
    i_sprite5 = r[4:0];
    i_sprite_overflow = 1'b1;
    bus_access(16'h00BF, 8'h00, 1'b1, 1'b0);
    i_sprite_overflow = 1'b0;
    for (int i = 0; i < 3; i++) begin
      random_bits(7, r);
      i_btn = r[6:0];
      bus_access(16'h00DC + 16'(i), 8'h00, 1'b1, 1'b0);
    end

    for (int i = 0; i < 7; i++) begin
      if (dut.u_checker.hits[i] == 0) begin
        errors++;
        $display("Check group %0d was never exercised", i);
      end
    end
    assert_fails = dut.u_checker.fail_count;
    $display("Errors: %0d, assertion failures: %0d", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* sms_io.f */
src/sms_bus_pkg.sv
src/vdp_pkg.sv
src/cpu_clock_enable.sv
src/sync_ram.sv
src/io_bus_decoder.sv
src/vdp_control_port.sv
src/vdp_register_decode.sv
src/sms_io_top.sv
dv/sms_io_assertions.sv
dv/sms_io_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sms_io.f --top-module sms_io_tb -o sms_io_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sms_io_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
  exit 0
fi
exit 1
